// File: holdoff_counter.sv
/* hold-off timer, done is a level while the count sits at its last value */
`default_nettype none
`include "ping_defines.svh"

module holdoff_counter import ping_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  count_cmd_t count_cmd,
    output logic       holdoff_done
);

    localparam int CNT_W = $clog2(`HOLDOFF_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`HOLDOFF_CYCLES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            count <= '0;
        end else begin
            case (count_cmd)
                ZERO:    count <= '0;
                // stop at the end, no wrap back to zero
                COUNT:   if (!holdoff_done) count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign holdoff_done = (count == LAST);

endmodule

`default_nettype wire

// File: ping_cases.txt
# 16 sample bytes in hex, oldest first, then the expected lag index in hex
# only the last sample of a line reaches the trigger level (c8 = 200)
28 78 78 28 00 00 00 00 00 00 00 00 00 00 00 C8 00
00 00 00 28 78 78 28 00 00 00 00 00 00 00 00 C8 03
00 00 00 00 00 00 00 28 78 78 28 00 00 00 00 C8 07
00 00 00 00 00 00 00 00 00 00 00 28 78 78 28 C8 0B
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 C8 0C
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 FF 0C
00 00 14 3C 3C 14 00 00 00 28 78 78 28 00 00 C8 09
00 28 78 78 28 00 00 00 28 78 78 28 00 00 00 C8 01
0A 0A 0A 0A 0A 28 78 78 28 0A 0A 0A 0A 0A 0A C8 05
C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C7 C8 0C
00 00 00 00 00 00 C7 00 00 00 00 00 00 00 00 C8 04
00 00 00 00 00 00 00 00 00 00 28 78 78 28 00 C8 0A

// File: ping_ctrl_pkg.sv
/* state and command types of the pipeline controller */
`default_nettype none

package ping_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        TRIGGERED,
        WAIT_FOR_CC,
        TX_EN,
        HOLDOFF
    } ctrl_state_t;

    // hold-off counter command
    typedef enum logic [1:0] {ZERO, HOLD, COUNT} count_cmd_t;

endpackage

`default_nettype wire

// File: ping_data_pkg.sv
/* data word types of the ping datapath, all unsigned */
`default_nettype none
`include "ping_defines.svh"

package ping_data_pkg;

    // one adc sample
    typedef logic [7:0] sample_t;
    // template coefficient
    typedef logic [3:0] tap_t;
    // sum of NUM_TAPS products, 255 * 8 worst case
    typedef logic [15:0] corr_t;
    // lag index, wide enough for any lag in the window
    typedef logic [$clog2(`WIN_DEPTH)-1:0] lag_t;

endpackage

`default_nettype wire

// File: ping_defines.svh
/* sizes and timing of the ping detector, all in clk cycles.
   WIN_DEPTH must exceed NUM_TAPS and UART_BIT_CYCLES must be at least 2 */
`ifndef PING_DEFINES_SVH
`define PING_DEFINES_SVH

// correlation window and ping template
`define WIN_DEPTH        16
`define NUM_TAPS         4
`define TEMPLATE_TAP0    1
`define TEMPLATE_TAP1    3
`define TEMPLATE_TAP2    3
`define TEMPLATE_TAP3    1

// sample value at or above this fires a trigger
`define TRIGGER_LEVEL    200

// deaf time after a frame, and serial bit length
`define HOLDOFF_CYCLES   300
`define UART_BIT_CYCLES  8

`endif

// File: ping_top.sv
/* single-channel ping detector, all blocks on one clock.
   samples while spi_en is low are dropped */
`default_nettype none

module ping_top import ping_data_pkg::*, ping_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t sample_in,
    input  logic    sample_valid,
    output logic    spi_en,
    output logic    trigger_persistent,
    output logic    tx
);

    logic       trigger;
    logic       start_cc;
    logic       cc_done;
    logic       tx_en;
    logic       tx_done;
    logic       holdoff_done;
    count_cmd_t count_cmd;
    lag_t       max_lag;
    logic [7:0] tx_byte;

    // lag goes out zero-extended
    assign tx_byte = 8'(max_lag);

    threshold_trigger u_trigger (
        .clk, .reset_b, .sample_in, .sample_valid, .spi_en, .trigger
    );

    window_correlator u_correlator (
        .clk, .reset_b, .sample_in, .sample_valid, .spi_en, .start_cc,
        .cc_done, .max_lag
    );

    uart_tx u_uart_tx (
        .clk, .reset_b, .tx_en, .data(tx_byte), .tx, .tx_done
    );

    holdoff_counter u_holdoff (
        .clk, .reset_b, .count_cmd, .holdoff_done
    );

    pipeline_controller u_ctrl (
        .clk, .reset_b, .trigger, .cc_done, .tx_done, .holdoff_done,
        .start_cc, .tx_en, .spi_en, .trigger_persistent, .count_cmd
    );

endmodule

`default_nettype wire

// File: pipeline_controller.sv
/* sequences one ping: trigger, correlation, uart frame, hold-off.
   plain levels and pulses only, the neighbours never stall */
`default_nettype none

module pipeline_controller import ping_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       trigger,
    input  logic       cc_done,
    input  logic       tx_done,
    input  logic       holdoff_done,
    output logic       start_cc,
    output logic       tx_en,
    output logic       spi_en,
    output logic       trigger_persistent,
    output count_cmd_t count_cmd
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // listening for a ping
            IDLE:        if (trigger) next_state = TRIGGERED;
            // start_cc goes out for this one cycle
            TRIGGERED:   next_state = WAIT_FOR_CC;
            WAIT_FOR_CC: if (cc_done) next_state = TX_EN;
            // tx_en held until the stop bit ends
            TX_EN:       if (tx_done) next_state = HOLDOFF;
            // let the echo die out
            HOLDOFF:     if (holdoff_done) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // moore decode of the outputs
    assign spi_en   = (state == IDLE);
    assign start_cc = (state == TRIGGERED);
    assign tx_en    = (state == TX_EN);
    assign trigger_persistent = (state == TRIGGERED) ||
                                (state == WAIT_FOR_CC) ||
                                (state == TX_EN);

    // counter runs only in hold-off, cleared elsewhere so it starts at zero
    assign count_cmd = (state == HOLDOFF) ? COUNT : ZERO;

    // correlator answers only the start issued from TRIGGERED
    assert property (@(posedge clk) disable iff (!reset_b)
        cc_done |-> (state == WAIT_FOR_CC))
        else $error("cc_done outside WAIT_FOR_CC");

    // frame ends only while tx_en is held
    assert property (@(posedge clk) disable iff (!reset_b)
        tx_done |-> (state == TX_EN))
        else $error("tx_done outside TX_EN");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the ping detector testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_ping_top

out=$(./obj_dir/Vtb_ping_top)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+.
ping_data_pkg.sv
ping_ctrl_pkg.sv
pipeline_controller.sv
holdoff_counter.sv
threshold_trigger.sv
window_correlator.sv
uart_tx.sv
ping_top.sv
tb_clock_gen.sv
tb_ping_top.sv

// File: tb_clock_gen.sv
/* free-running testbench clock, starts low */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tb_ping_top.sv
/* one ping per line of ping_cases.txt, lag byte decoded from tx.
   inputs change on rising edges, outputs are sampled on falling edges */
`default_nettype none
`include "ping_defines.svh"

module tb_ping_top import ping_data_pkg::*; ();

    logic    clk;
    logic    reset_b;
    sample_t sample_in;
    logic    sample_valid;
    logic    spi_en;
    logic    trigger_persistent;
    logic    tx;

    int   errors;
    int   timeouts;
    int   cases_run;
    logic aborted;

    // current case, oldest sample first
    sample_t    smp [`WIN_DEPTH];
    logic [7:0] exp_lag;

    tb_clock_gen #(.PERIOD(20)) u_clock (
        .clk(clk)
    );

    ping_top dut (
        .clk, .reset_b, .sample_in, .sample_valid, .spi_en, .trigger_persistent, .tx
    );

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] expected);
        errors++;
        $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, expected);
    endtask

    // reference argmax, first of equal peaks wins
    function automatic logic [7:0] best_lag_of();
        int lag;
        int sum;
        int best_sum;
        int best_lag;

        best_sum = 0;
        best_lag = 0;
        for (lag = 0; lag <= `WIN_DEPTH - `NUM_TAPS; lag++) begin
            sum = int'(smp[lag]) * `TEMPLATE_TAP0 + int'(smp[lag + 1]) * `TEMPLATE_TAP1 +
                  int'(smp[lag + 2]) * `TEMPLATE_TAP2 + int'(smp[lag + 3]) * `TEMPLATE_TAP3;
            if (sum > best_sum) begin
                best_sum = sum;
                best_lag = lag;
            end
        end
        return 8'(best_lag);
    endfunction

    task automatic apply_reset();
        reset_b      = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        repeat (2) @(posedge clk);
        reset_b <= 1'b1;
    endtask

    // listen says whether the DUT should be taking samples right now
    task automatic drive_sample(input sample_t value, input logic listen);
        @(negedge clk);
        assert (spi_en === listen) else report_mismatch("spi_en", 8'(spi_en), 8'(listen));
        @(posedge clk);
        sample_in    <= value;
        sample_valid <= 1'b1;
    endtask

    task automatic receive_byte(output logic [7:0] rx);
        int n;
        int i;

        rx = '0;
        n = 0;
        while (tx !== 1'b0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        assert (tx === 1'b0) else begin
            errors++;
            timeouts++;
            aborted = 1'b1;
            $display("timeout: no start bit on tx after %0d cycles", n);
        end
        if (aborted) return;
        // middle of the start bit, then one bit period per step
        repeat (`UART_BIT_CYCLES / 2 - 1) @(negedge clk);
        assert (tx === 1'b0) else report_mismatch("tx start bit", 8'(tx), 8'h0);
        for (i = 0; i < 8; i++) begin
            repeat (`UART_BIT_CYCLES) @(negedge clk);
            rx[i] = tx;
        end
        repeat (`UART_BIT_CYCLES) @(negedge clk);
        assert (tx === 1'b1) else report_mismatch("tx stop bit", 8'(tx), 8'h1);
    endtask

    task automatic run_case();
        int         i;
        int         n;
        int         gap;
        logic [7:0] rx;
        logic       quiet;

        cases_run++;
        assert (best_lag_of() === exp_lag)
            else report_mismatch("case file lag", exp_lag, best_lag_of());

        for (i = 0; i < `WIN_DEPTH; i++) begin
            drive_sample(smp[i], 1'b1);
            if (i < `WIN_DEPTH - 1) begin
                gap = int'($urandom_range(2, 0));
                repeat (gap) begin
                    @(posedge clk);
                    sample_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;

        // last sample is the loud one, controller leaves IDLE two clocks later
        n = 1;
        @(negedge clk);
        while ((spi_en !== 1'b0 || trigger_persistent !== 1'b1) && n < 3) begin
            @(negedge clk);
            n++;
        end
        assert (spi_en === 1'b0) else report_mismatch("spi_en", 8'(spi_en), 8'h0);
        assert (trigger_persistent === 1'b1)
            else report_mismatch("trigger_persistent", 8'(trigger_persistent), 8'h1);

        receive_byte(rx);
        if (aborted) return;
        assert (rx === exp_lag) else report_mismatch("tx byte", rx, exp_lag);

        // past the stop bit, loud samples now fall into the hold-off
        repeat (`UART_BIT_CYCLES) @(posedge clk);
        for (i = 0; i < 3; i++) begin
            drive_sample(sample_t'($urandom_range(255, `TRIGGER_LEVEL)), 1'b0);
            @(posedge clk);
            sample_valid <= 1'b0;
        end

        n = 0;
        quiet = 1'b1;
        while (spi_en !== 1'b1 && n < `HOLDOFF_CYCLES + 20) begin
            @(negedge clk);
            n++;
            if (tx !== 1'b1 || trigger_persistent !== 1'b0) begin
                quiet = 1'b0;
            end
        end
        assert (quiet) else begin
            errors++;
            $display("loud samples during the hold-off started a new frame");
        end
        assert (spi_en === 1'b1) else begin
            errors++;
            timeouts++;
            aborted = 1'b1;
            $display("timeout: spi_en still low %0d cycles after the frame", n);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;

        errors    = 0;
        timeouts  = 0;
        cases_run = 0;
        aborted   = 1'b0;
        void'($urandom(41644));
        apply_reset();

        @(negedge clk);
        assert (spi_en === 1'b1) else report_mismatch("spi_en", 8'(spi_en), 8'h1);
        assert (tx === 1'b1) else report_mismatch("tx", 8'(tx), 8'h1);
        assert (trigger_persistent === 1'b0)
            else report_mismatch("trigger_persistent", 8'(trigger_persistent), 8'h0);

        fd = $fopen("ping_cases.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("cannot open ping_cases.txt");
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        smp[0], smp[1], smp[2], smp[3], smp[4], smp[5], smp[6], smp[7],
                        smp[8], smp[9], smp[10], smp[11], smp[12], smp[13], smp[14],
                        smp[15], exp_lag);
            assert (n == 17) else begin
                errors++;
                $display("malformed line in ping_cases.txt: %s", line);
            end
            if (n == 17) run_case();
        end
        if (fd != 0) $fclose(fd);
        assert (cases_run > 0) else begin
            errors++;
            $display("no cases were run");
        end

        $display("cases %0d, errors %0d, timeouts %0d", cases_run, errors, timeouts);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: threshold_trigger.sv
/* one-cycle trigger, a clock after a loud valid sample, only while spi_en */
`default_nettype none
`include "ping_defines.svh"

module threshold_trigger import ping_data_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t sample_in,
    input  logic    sample_valid,
    input  logic    spi_en,
    output logic    trigger
);

    logic loud;

    assign loud = (sample_in >= sample_t'(`TRIGGER_LEVEL));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            trigger <= 1'b0;
        end else begin
            // back-to-back loud samples still give a single pulse
            trigger <= sample_valid && spi_en && loud && !trigger;
        end
    end

    // controller must still be listening when the pulse arrives
    assert property (@(posedge clk) disable iff (!reset_b)
        trigger |-> spi_en)
        else $error("trigger while spi_en low");

endmodule

`default_nettype wire

// File: uart_tx.sv
/* 8N1 transmitter, UART_BIT_CYCLES clocks per bit, line idles high.
   data is sampled on the clock a frame starts */
`default_nettype none
`include "ping_defines.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       tx_en,
    input  logic [7:0] data,
    output logic       tx,
    output logic       tx_done
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_BIT_CYCLES - 1);

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    // start, 8 data and stop bit
    logic [3:0]       bit_idx;
    logic [9:0]       frame;
    logic             bit_end;

    assign bit_end = (bit_cnt == BIT_LAST);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (tx_en) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // lsb first, shifted out at each bit end
    always_ff @(posedge clk) begin
        if (!busy && tx_en) begin
            frame <= {1'b1, data, 1'b0};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    assign tx      = busy ? frame[0] : 1'b1;
    assign tx_done = busy && bit_end && (bit_idx == 4'd9);

endmodule

`default_nettype wire

// File: window_correlator.sv
/* sliding four-tap correlation over a frozen window, one lag per cycle.
   window holds X until WIN_DEPTH samples have arrived */
`default_nettype none
`include "ping_defines.svh"

module window_correlator import ping_data_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  sample_t sample_in,
    input  logic    sample_valid,
    input  logic    spi_en,
    input  logic    start_cc,
    output logic    cc_done,
    output lag_t    max_lag
);

    localparam lag_t LAST_LAG = lag_t'(`WIN_DEPTH - `NUM_TAPS);

    localparam tap_t TAPS [`NUM_TAPS] = '{
        tap_t'(`TEMPLATE_TAP0),
        tap_t'(`TEMPLATE_TAP1),
        tap_t'(`TEMPLATE_TAP2),
        tap_t'(`TEMPLATE_TAP3)
    };

    // index 0 is the oldest sample
    sample_t window [`WIN_DEPTH];

    logic  busy;
    lag_t  lag;
    corr_t lag_sum;
    corr_t best_sum;
    lag_t  best_lag;

    // shift only while listening, frozen once the controller leaves IDLE
    always_ff @(posedge clk) begin
        if (sample_valid && spi_en) begin
            for (int i = 0; i < `WIN_DEPTH - 1; i++) begin
                window[i] <= window[i+1];
            end
            window[`WIN_DEPTH-1] <= sample_in;
        end
    end

    // products of the current lag
    always_comb begin
        lag_sum = '0;
        for (int k = 0; k < `NUM_TAPS; k++) begin
            lag_sum = lag_sum + corr_t'(window[int'(lag) + k]) * corr_t'(TAPS[k]);
        end
    end

    // scan lags 0..LAST_LAG, done pulse one cycle after the last one
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            busy     <= 1'b0;
            lag      <= '0;
            cc_done  <= 1'b0;
            best_sum <= '0;
            best_lag <= '0;
        end else begin
            cc_done <= 1'b0;
            if (start_cc) begin
                busy     <= 1'b1;
                lag      <= '0;
                best_sum <= '0;
                best_lag <= '0;
            end else if (busy) begin
                // strict compare keeps the first of equal peaks
                if (lag_sum > best_sum) begin
                    best_sum <= lag_sum;
                    best_lag <= lag;
                end
                if (lag == LAST_LAG) begin
                    busy    <= 1'b0;
                    cc_done <= 1'b1;
                end else begin
                    lag <= lag + 1'b1;
                end
            end
        end
    end

    // stable from cc_done until the next start
    assign max_lag = best_lag;

    // a restart mid-scan would report a lag from two windows
    assert property (@(posedge clk) disable iff (!reset_b)
        start_cc |-> !busy)
        else $error("start_cc while a scan is running");

endmodule

`default_nettype wire
